// ==== boot_rom.sv ====
/* Read-only boot memory on the peripheral bus.
   Contents come from the package content function at build time */
`timescale 1ns/1ps

module boot_rom #(
	parameter int ROM_WORDS = 256
) (
	input  logic        cpu_clk,
	input  logic        rst_n_i,
	periph_bus_if.slave bus
);
	import sys_pkg::*;

	localparam int AW = $clog2(ROM_WORDS);

	data_t rom_mem [ROM_WORDS];
	logic [AW-1:0] word_idx;

	// Fill the array once, the synthesizer folds it into ROM
	initial begin
		for (int i = 0; i < ROM_WORDS; i++)
			rom_mem[i] = boot_word(i);
	end

	// Word index, byte address bit 0 ignored
	assign word_idx = bus.adr[AW:1];

	// Ack follows sel and strobe one clock late
	// Writes get acked too, the data is dropped
	always_ff @(posedge cpu_clk or negedge rst_n_i) begin
		if (!rst_n_i)
			bus.ack <= 1'b0;
		else
			bus.ack <= bus.sel & bus.strobe;
	end

	// Registered read port
	always_ff @(posedge cpu_clk) begin
		if (bus.sel && bus.strobe)
			bus.rdata <= rom_mem[word_idx];
	end

endmodule

// ==== bus_decoder.sv ====
/* Address decoder and bus-cycle FSM between the 68000 bus and the slaves.
   Registers the reply into data_o and dtack_n_o, or raises berr_o on timeout */
`timescale 1ns/1ps

module bus_decoder #(
	parameter int BERR_CYCLES = 16
) (
	input  logic           cpu_clk,
	input  logic           rst_n_i,
	input  logic           as_n_i,
	input  logic           rw_i,
	input  logic           uds_n_i,
	input  logic           lds_n_i,
	input  sys_pkg::addr_t addr_i,
	input  sys_pkg::data_t data_i,
	output sys_pkg::data_t data_o,
	output logic           dtack_n_o,
	output logic           berr_o,
	periph_bus_if.master   rom_bus,
	periph_bus_if.master   ram_bus,
	periph_bus_if.master   prng_bus,
	periph_bus_if.master   led_bus
);
	import sys_pkg::*;

	localparam int CNT_W = $clog2(BERR_CYCLES + 1);
	// strobe, we, be, adr, wdata
	localparam int REQ_W = 4 + $bits(addr_t) + $bits(data_t);

	logic strobe;
	logic [REQ_W-1:0] req;
	logic cs_rom;
	logic cs_ram;
	logic cs_prng;
	logic cs_led;
	logic any_ack;
	data_t rdata;
	dec_state_e state;
	logic [CNT_W-1:0] berr_cnt;

	// ============================================================
	// Request side
	// ============================================================

	// Strobes go active high towards the slaves
	assign strobe = ~as_n_i;
	assign req = {strobe, ~rw_i, ~uds_n_i, ~lds_n_i, addr_i, data_i};

	// Address map, the regions do not overlap
	assign cs_rom = addr_i[31:20] == BOOT_BASE[31:20];
	assign cs_ram = addr_i[31:16] == RAM_BASE[31:16];
	assign cs_led = addr_i[31:4] == LED_ADDR[31:4];
	assign cs_prng = addr_i[31:4] == PRNG_ADDR[31:4];

	// Same request to every slave, only the select differs
	assign rom_bus.sel = cs_rom;
	assign ram_bus.sel = cs_ram;
	assign prng_bus.sel = cs_prng;
	assign led_bus.sel = cs_led;
	assign {rom_bus.strobe, rom_bus.we, rom_bus.be, rom_bus.adr, rom_bus.wdata} = req;
	assign {ram_bus.strobe, ram_bus.we, ram_bus.be, ram_bus.adr, ram_bus.wdata} = req;
	assign {prng_bus.strobe, prng_bus.we, prng_bus.be, prng_bus.adr, prng_bus.wdata} = req;
	assign {led_bus.strobe, led_bus.we, led_bus.be, led_bus.adr, led_bus.wdata} = req;

	// ============================================================
	// Reply side
	// ============================================================

	// Slaves only ack while selected, so a plain OR is enough
	assign any_ack = rom_bus.ack | ram_bus.ack | prng_bus.ack | led_bus.ack;

	always_comb begin
		if (cs_rom)
			rdata = rom_bus.rdata;
		else if (cs_ram)
			rdata = ram_bus.rdata;
		else if (cs_prng)
			rdata = prng_bus.rdata;
		else
			rdata = led_bus.rdata;
	end

	// Cycle FSM, dtack and berr held until the master drops as_n
	always_ff @(posedge cpu_clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state <= IDLE;
			berr_cnt <= '0;
			dtack_n_o <= 1'b1;
			berr_o <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					berr_cnt <= '0;
					if (strobe)
						state <= WAIT_ACK;
				end
				WAIT_ACK: begin
					// Aborted cycle, nothing to answer
					if (!strobe) begin
						state <= IDLE;
					end else if (any_ack) begin
						dtack_n_o <= 1'b0;
						state <= HOLD;
					end else if (berr_cnt == CNT_W'(BERR_CYCLES - 1)) begin
						berr_o <= 1'b1;
						state <= ERR;
					end else begin
						berr_cnt <= berr_cnt + 1'b1;
					end
				end
				HOLD: begin
					if (!strobe) begin
						dtack_n_o <= 1'b1;
						state <= IDLE;
					end
				end
				ERR: begin
					if (!strobe) begin
						berr_o <= 1'b0;
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Read data captured together with the acknowledge
	always_ff @(posedge cpu_clk) begin
		if (state == WAIT_ACK && any_ack)
			data_o <= rdata;
	end

endmodule

// ==== led_port.sv ====
/* LED register with debounced buttons on the peripheral bus.
   A held button shows one byte of the bus address instead of the register */
`timescale 1ns/1ps

module led_port #(
	parameter int DEBOUNCE_CYCLES = 8
) (
	input  logic        cpu_clk,
	input  logic        rst_n_i,
	periph_bus_if.slave bus,
	input  logic [2:0]  btn_i,
	output logic [7:0]  led_o
);
	import sys_pkg::*;

	localparam int DW = $clog2(DEBOUNCE_CYCLES + 1);

	logic [7:0] led_reg;
	logic [2:0] btn_db;
	logic [DW-1:0] db_cnt [3];
	logic first;

	assign first = bus.sel & bus.strobe & ~bus.ack;

	// Register write on the low byte lane
	always_ff @(posedge cpu_clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			led_reg <= '0;
			bus.ack <= 1'b0;
		end else begin
			bus.ack <= bus.sel & bus.strobe;
			if (first && bus.we && bus.be[0])
				led_reg <= bus.wdata[7:0];
		end
	end

	always_ff @(posedge cpu_clk) begin
		if (first)
			bus.rdata <= data_t'(led_reg);
	end

	// Debounce, the view follows the raw input only after it has
	// differed for DEBOUNCE_CYCLES clocks in a row
	always_ff @(posedge cpu_clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			btn_db <= '0;
			for (int i = 0; i < 3; i++)
				db_cnt[i] <= '0;
		end else begin
			for (int i = 0; i < 3; i++) begin
				if (btn_i[i] == btn_db[i]) begin
					db_cnt[i] <= '0;
				end else if (db_cnt[i] == DW'(DEBOUNCE_CYCLES - 1)) begin
					btn_db[i] <= btn_i[i];
					db_cnt[i] <= '0;
				end else begin
					db_cnt[i] <= db_cnt[i] + 1'b1;
				end
			end
		end
	end

	// Button 0 has priority, then 1, then 2
	assign led_o = btn_db[0] ? bus.adr[23:16] :
	               btn_db[1] ? bus.adr[15:8] :
	               btn_db[2] ? bus.adr[7:0] :
	               led_reg;

endmodule

// ==== periph_bus_if.sv ====
/* Request and reply signals between the bus decoder and one slave.
   The decoder holds the master side, each peripheral the slave side */
`timescale 1ns/1ps

interface periph_bus_if;
	import sys_pkg::*;

	// Chip select from the address map
	logic sel;
	// Address strobe, active high
	logic strobe;
	logic we;
	strb_t be;
	addr_t adr;
	data_t wdata;
	// Reply, valid while ack is high
	data_t rdata;
	logic ack;

	// Decoder side
	modport master (output sel, strobe, we, be, adr, wdata, input rdata, ack);
	// Peripheral side
	modport slave (input sel, strobe, we, be, adr, wdata, output rdata, ack);

endinterface

// ==== prng_unit.sv ====
/* Seedable 32-bit Galois LFSR on the peripheral bus.
   Offsets 0 and 2 load the state halves, a read of offset 4 steps it once */
`timescale 1ns/1ps

module prng_unit (
	input  logic        cpu_clk,
	input  logic        rst_n_i,
	periph_bus_if.slave bus
);
	import sys_pkg::*;

	lfsr_t state;
	lfsr_t load_val;
	logic [2:0] reg_sel;
	logic first;

	// One right shift, taps folded in when bit 0 falls out
	function automatic lfsr_t lfsr_next(input lfsr_t s);
		return s[0] ? ((s >> 1) ^ LFSR_POLY) : (s >> 1);
	endfunction

	// Word offset inside the block
	assign reg_sel = bus.adr[3:1];

	// First clock of a selected cycle, the one where ack rises
	assign first = bus.sel & bus.strobe & ~bus.ack;

	// Candidate state for a write, the other half is kept
	always_comb begin
		load_val = state;
		if (reg_sel == 3'd0)
			load_val[31:16] = bus.wdata;
		else
			load_val[15:0] = bus.wdata;
	end

	always_ff @(posedge cpu_clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state <= LFSR_ALT_SEED;
			bus.ack <= 1'b0;
		end else begin
			bus.ack <= bus.sel & bus.strobe;
			if (first) begin
				// Seed load, an all-zero state is replaced
				if (bus.we && reg_sel <= 3'd1)
					state <= (load_val == '0) ? LFSR_ALT_SEED : load_val;
				// Output read steps once per bus cycle, not per clock
				else if (!bus.we && reg_sel == 3'd2)
					state <= lfsr_next(state);
			end
		end
	end

	// Offset 0 reads back the upper half, the rest the low half
	always_ff @(posedge cpu_clk) begin
		if (first)
			bus.rdata <= (reg_sel == 3'd0) ? state[31:16] : state[15:0];
	end

endmodule

// ==== scratch_ram.sv ====
/* Byte-writable scratch RAM on the peripheral bus.
   Answers each access after RAM_WAIT wait states */
`timescale 1ns/1ps

module scratch_ram #(
	parameter int RAM_WORDS = 1024,
	parameter int RAM_WAIT = 3
) (
	input  logic        cpu_clk,
	input  logic        rst_n_i,
	periph_bus_if.slave bus
);
	import sys_pkg::*;

	localparam int AW = $clog2(RAM_WORDS);
	// At least one bit even with no wait states
	localparam int WCW = $clog2(RAM_WAIT + 2);

	data_t ram_mem [RAM_WORDS];
	logic [WCW-1:0] wait_cnt;
	logic [AW-1:0] word_idx;
	logic access;

	assign word_idx = bus.adr[AW:1];

	// One access slot per bus cycle, at the end of the wait
	assign access = bus.sel & bus.strobe & ~bus.ack & (wait_cnt == WCW'(RAM_WAIT));

	// Wait counter runs while selected, ack holds until strobe drops
	always_ff @(posedge cpu_clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wait_cnt <= '0;
			bus.ack <= 1'b0;
		end else if (!(bus.sel && bus.strobe)) begin
			wait_cnt <= '0;
			bus.ack <= 1'b0;
		end else if (access) begin
			bus.ack <= 1'b1;
		end else if (!bus.ack) begin
			wait_cnt <= wait_cnt + 1'b1;
		end
	end

	// Memory port, byte lanes written separately
	always_ff @(posedge cpu_clk) begin
		if (access) begin
			if (bus.we && bus.be[1])
				ram_mem[word_idx][15:8] <= bus.wdata[15:8];
			if (bus.we && bus.be[0])
				ram_mem[word_idx][7:0] <= bus.wdata[7:0];
			bus.rdata <= ram_mem[word_idx];
		end
	end

endmodule

// ==== sources.f ====
sys_pkg.sv
periph_bus_if.sv
bus_decoder.sv
boot_rom.sv
scratch_ram.sv
prng_unit.sv
led_port.sv
v68k_sys.sv
v68k_sys_assert.sv
tb_v68k_sys.sv

// ==== sys_pkg.sv ====
/* Shared bus types, memory map and constants of the 68000-style system.
   Imported by the bus interface, the decoder and every slave */
package sys_pkg;

	// ============================================================
	// Bus types
	// ============================================================

	// Byte address as driven by the bus master
	typedef logic [31:0] addr_t;
	// One bus data word
	typedef logic [15:0] data_t;
	// Byte strobes in active-high form, upper byte in bit 1
	typedef logic [1:0] strb_t;
	// Random generator state
	typedef logic [31:0] lfsr_t;

	// ============================================================
	// Memory map
	// ============================================================

	// Boot ROM, only bits 31:20 are compared
	localparam addr_t BOOT_BASE = 32'hFFF0_0000;
	// Scratch RAM, only bits 31:16 are compared
	localparam addr_t RAM_BASE = 32'h0000_0000;
	// Register blocks decode bits 31:4
	localparam addr_t LED_ADDR = 32'hFFDC_0600;
	localparam addr_t PRNG_ADDR = 32'hFFDC_0C00;

	// Galois taps, applied when bit 0 shifts out
	localparam lfsr_t LFSR_POLY = 32'h8020_0003;
	// Stored in place of an all-zero load, which would lock up the LFSR
	localparam lfsr_t LFSR_ALT_SEED = 32'h0000_0001;

	// Decoder FSM
	typedef enum logic [1:0] {IDLE, WAIT_ACK, HOLD, ERR} dec_state_e;

	// Boot ROM content, word index scrambled with a fixed pattern
	function automatic data_t boot_word(input int unsigned idx);
		int unsigned prod;
		prod = idx * 32'h0000_0101;
		return data_t'(prod ^ 32'h0000_A5C3);
	endfunction

endpackage

// ==== tb_v68k_sys.sv ====
/* Directed testbench for the system top, one task per feature.
   Runs ROM, RAM, PRNG, LED, button view and bus error cycles in turn */
`timescale 1ns/1ps

module tb_v68k_sys;
	import sys_pkg::*;

	localparam int RAM_WAIT = 3;
	localparam int RAM_WORDS = 1024;
	localparam int ROM_WORDS = 256;
	localparam int BERR_CYCLES = 16;
	localparam int DEBOUNCE_CYCLES = 8;
	// Longest wait for any reply, well past the bus error window
	localparam int REPLY_LIMIT = 64;
	// Register address with distinct bytes for the button views
	localparam addr_t VIEW_ADDR = 32'hFFDC_060A;

	logic cpu_clk;
	logic rst_n_i;
	logic as_n_i;
	logic rw_i;
	logic uds_n_i;
	logic lds_n_i;
	addr_t addr_i;
	data_t data_i;
	data_t data_o;
	logic dtack_n_o;
	logic berr_o;
	logic [2:0] btn_i;
	logic [7:0] led_o;

	int errors;
	int checks;
	logic [31:0] lcg_state;
	// Last value written to the LED register
	logic [7:0] led_value;

	v68k_sys #(
		.RAM_WAIT(RAM_WAIT),
		.RAM_WORDS(RAM_WORDS),
		.ROM_WORDS(ROM_WORDS),
		.BERR_CYCLES(BERR_CYCLES),
		.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
	) dut0 (.*);

	initial cpu_clk = 1'b0;
	always #20 cpu_clk = ~cpu_clk;

	// ============================================================
	// Reference models
	// ============================================================

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Boot content, index times 0x0101 scrambled with 0xA5C3
	function automatic data_t rom_word(input int idx);
		logic [31:0] w;
		w = idx * 32'h0000_0101;
		return data_t'(w ^ 32'h0000_A5C3);
	endfunction

	// Galois step, shift right and apply the taps on a one out
	function automatic lfsr_t lfsr_step(input lfsr_t s);
		lfsr_t n;
		n = {1'b0, s[31:1]};
		if (s[0])
			n = n ^ LFSR_POLY;
		return n;
	endfunction

	// ============================================================
	// Compare and report
	// ============================================================

	task automatic check_data(input string name, input data_t exp, input data_t act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("Mismatch %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("Mismatch %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	// Cycle counts such as reply latency
	task automatic check_count(input string name, input int exp, input int act);
		checks++;
		if (exp != act) begin
			errors++;
			$display("Mismatch %s: expected %0d, actual %0d", name, exp, act);
		end
	endtask

	task automatic test_done(input string name, input int errs0);
		$display("%-12s finished with %0d error(s)", name, errors - errs0);
	endtask

	// ============================================================
	// Bus cycle tasks
	// ============================================================

	task automatic bus_start(input addr_t a, input logic rd, input strb_t be, input data_t wd);
		@(posedge cpu_clk);
		addr_i <= a;
		rw_i <= rd;
		uds_n_i <= ~be[1];
		lds_n_i <= ~be[0];
		data_i <= wd;
		as_n_i <= 1'b0;
	endtask

	// Counts rising edges from the first one that sees as_n_i low
	// until dtack or berr
	task automatic bus_wait(input string name, output int lat);
		lat = 0;
		do begin
			@(posedge cpu_clk);
			lat++;
			@(negedge cpu_clk);
		end while (dtack_n_o && !berr_o && lat < REPLY_LIMIT);
		if (dtack_n_o && !berr_o) begin
			errors++;
			$display("Timeout in %s: neither dtack_n_o nor berr_o came", name);
		end
	endtask

	// Drop the strobes, then wait for both replies to go inactive
	task automatic bus_release(input string name);
		int n;
		@(posedge cpu_clk);
		as_n_i <= 1'b1;
		uds_n_i <= 1'b1;
		lds_n_i <= 1'b1;
		rw_i <= 1'b1;
		n = 0;
		do begin
			@(negedge cpu_clk);
			n++;
		end while ((!dtack_n_o || berr_o) && n < REPLY_LIMIT);
		if (!dtack_n_o || berr_o) begin
			errors++;
			$display("Timeout in %s: reply still active after as_n_i rose", name);
		end
	endtask

	// Extra hold cycles stretch the cycle past dtack
	task automatic bus_read(input string name, input addr_t a, input int hold,
		output data_t d, output int lat);
		bus_start(a, 1'b1, 2'b11, '0);
		bus_wait(name, lat);
		d = data_o;
		repeat (hold) @(posedge cpu_clk);
		bus_release(name);
	endtask

	task automatic bus_write(input string name, input addr_t a, input strb_t be,
		input data_t wd, output int lat);
		bus_start(a, 1'b0, be, wd);
		bus_wait(name, lat);
		bus_release(name);
	endtask

	// ============================================================
	// Tests
	// ============================================================

	task automatic rom_read_test();
		int errs0;
		int idx;
		int lat;
		data_t rd;
		errs0 = errors;
		for (int i = 0; i < 16; i++) begin
			idx = int'((lcg_next() >> 16) % ROM_WORDS);
			bus_read("rom_read", BOOT_BASE | (addr_t'(idx) << 1), 0, rd, lat);
			check_data($sformatf("rom_read[%0d]", idx), rom_word(idx), rd);
			check_count("rom_read latency", 2, lat);
		end
		test_done("rom_read", errs0);
	endtask

	task automatic ram_test();
		data_t ram_model [RAM_WORDS];
		int idx_q[$];
		int errs0;
		int idx;
		int lat;
		data_t wd;
		data_t rd;
		errs0 = errors;
		for (int i = 0; i < 9; i++) begin
			idx = int'((lcg_next() >> 16) % RAM_WORDS);
			wd = data_t'(lcg_next() >> 8);
			bus_write("ram_write", RAM_BASE | (addr_t'(idx) << 1), 2'b11, wd, lat);
			check_count("ram_write latency", RAM_WAIT + 2, lat);
			ram_model[idx] = wd;
			wd = data_t'(lcg_next() >> 8);
			// Every third word gets a single-byte overwrite
			if (i % 3 == 1) begin
				bus_write("ram_write_hi", RAM_BASE | (addr_t'(idx) << 1), 2'b10, wd, lat);
				ram_model[idx][15:8] = wd[15:8];
			end else if (i % 3 == 2) begin
				bus_write("ram_write_lo", RAM_BASE | (addr_t'(idx) << 1), 2'b01, wd, lat);
				ram_model[idx][7:0] = wd[7:0];
			end
			idx_q.push_back(idx);
		end
		foreach (idx_q[k]) begin
			bus_read("ram_read", RAM_BASE | (addr_t'(idx_q[k]) << 1), 0, rd, lat);
			check_data($sformatf("ram_read[%0d]", idx_q[k]), ram_model[idx_q[k]], rd);
			check_count("ram_read latency", RAM_WAIT + 2, lat);
		end
		test_done("ram_rw", errs0);
	endtask

	// Upper half first, a zero result falls back to the alternate seed
	task automatic prng_load(inout lfsr_t model, input lfsr_t seed);
		int lat;
		bus_write("prng_seed_hi", PRNG_ADDR, 2'b11, seed[31:16], lat);
		model[31:16] = seed[31:16];
		if (model == '0)
			model = LFSR_ALT_SEED;
		bus_write("prng_seed_lo", PRNG_ADDR + 2, 2'b11, seed[15:0], lat);
		model[15:0] = seed[15:0];
		if (model == '0)
			model = LFSR_ALT_SEED;
	endtask

	task automatic prng_test();
		lfsr_t model;
		int errs0;
		int lat;
		data_t rd;
		errs0 = errors;
		model = LFSR_ALT_SEED;
		prng_load(model, lcg_next());
		for (int i = 0; i < 5; i++) begin
			bus_read("prng_read", PRNG_ADDR + 4, 0, rd, lat);
			check_data($sformatf("prng_read[%0d]", i), model[15:0], rd);
			model = lfsr_step(model);
		end
		// Zero seed restarts from the alternate seed
		prng_load(model, '0);
		bus_read("prng_zero", PRNG_ADDR + 4, 0, rd, lat);
		check_data("prng_zero first", LFSR_ALT_SEED[15:0], rd);
		model = lfsr_step(LFSR_ALT_SEED);
		for (int i = 0; i < 2; i++) begin
			bus_read("prng_zero", PRNG_ADDR + 4, 0, rd, lat);
			check_data($sformatf("prng_zero[%0d]", i), model[15:0], rd);
			model = lfsr_step(model);
		end
		// Stretched read, the following read must see a single step
		bus_read("prng_hold", PRNG_ADDR + 4, 6, rd, lat);
		check_data("prng_hold", model[15:0], rd);
		model = lfsr_step(model);
		bus_read("prng_after_hold", PRNG_ADDR + 4, 0, rd, lat);
		check_data("prng_after_hold", model[15:0], rd);
		test_done("prng_seq", errs0);
	endtask

	task automatic led_test();
		int errs0;
		int lat;
		data_t wd;
		data_t rd;
		errs0 = errors;
		wd = data_t'(lcg_next() >> 12);
		led_value = wd[7:0];
		bus_write("led_write", LED_ADDR, 2'b01, wd, lat);
		bus_read("led_read", LED_ADDR, 0, rd, lat);
		check_data("led_read", data_t'(led_value), rd);
		@(negedge cpu_clk);
		check_data("led_o register", data_t'(led_value), data_t'(led_o));
		test_done("led_reg", errs0);
	endtask

	// Buttons pressed while a stretched read holds VIEW_ADDR on the bus
	task automatic button_test();
		logic [7:0] view [3];
		int errs0;
		int lat;
		errs0 = errors;
		view[0] = VIEW_ADDR[23:16];
		view[1] = VIEW_ADDR[15:8];
		view[2] = VIEW_ADDR[7:0];
		bus_start(VIEW_ADDR, 1'b1, 2'b11, '0);
		bus_wait("button_view", lat);
		for (int b = 0; b < 3; b++) begin
			@(posedge cpu_clk);
			btn_i <= 3'b001 << b;
			repeat (DEBOUNCE_CYCLES + 2) @(posedge cpu_clk);
			@(negedge cpu_clk);
			check_data($sformatf("button %0d view", b), data_t'(view[b]), data_t'(led_o));
			@(posedge cpu_clk);
			btn_i <= '0;
			repeat (DEBOUNCE_CYCLES + 2) @(posedge cpu_clk);
			@(negedge cpu_clk);
			check_data($sformatf("button %0d release", b), data_t'(led_value),
				data_t'(led_o));
		end
		bus_release("button_view");
		test_done("button_view", errs0);
	endtask

	task automatic berr_test();
		int errs0;
		int lat;
		errs0 = errors;
		bus_start(32'h4000_0000, 1'b1, 2'b11, '0);
		bus_wait("bus_error", lat);
		check_flag("bus_error berr_o", 1'b1, berr_o);
		check_flag("bus_error dtack_n_o", 1'b1, dtack_n_o);
		check_count("bus_error latency", BERR_CYCLES + 1, lat);
		bus_release("bus_error");
		check_flag("bus_error berr_o cleared", 1'b0, berr_o);
		test_done("bus_error", errs0);
	endtask

	// ============================================================
	// Main sequence
	// ============================================================

	initial begin
		errors = 0;
		checks = 0;
		lcg_state = 32'h6b0b;
		led_value = '0;
		rst_n_i <= 1'b0;
		as_n_i <= 1'b1;
		rw_i <= 1'b1;
		uds_n_i <= 1'b1;
		lds_n_i <= 1'b1;
		addr_i <= '0;
		data_i <= '0;
		btn_i <= '0;
		repeat (4) @(posedge cpu_clk);
		rst_n_i <= 1'b1;
		rom_read_test();
		ram_test();
		prng_test();
		// LED register value is reused by the button view test
		led_test();
		button_test();
		berr_test();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

// ==== v68k_sys.sv ====
/* System top with the 68000 bus on plain ports.
   Connects the decoder to boot ROM, scratch RAM, PRNG and LED port */
`timescale 1ns/1ps

module v68k_sys #(
	parameter int RAM_WAIT = 3,
	parameter int RAM_WORDS = 1024,
	parameter int ROM_WORDS = 256,
	parameter int BERR_CYCLES = 16,
	parameter int DEBOUNCE_CYCLES = 8
) (
	input  logic           cpu_clk,
	input  logic           rst_n_i,
	// 68000 bus, strobes active low
	input  logic           as_n_i,
	input  logic           rw_i,
	input  logic           uds_n_i,
	input  logic           lds_n_i,
	input  sys_pkg::addr_t addr_i,
	input  sys_pkg::data_t data_i,
	output sys_pkg::data_t data_o,
	output logic           dtack_n_o,
	output logic           berr_o,
	// Board buttons and LEDs
	input  logic [2:0]     btn_i,
	output logic [7:0]     led_o
);

	// One bus per slave
	periph_bus_if rom_bus ();
	periph_bus_if ram_bus ();
	periph_bus_if prng_bus ();
	periph_bus_if led_bus ();

	// Decoder port names match the signals here
	bus_decoder #(
		.BERR_CYCLES(BERR_CYCLES)
	) u_dec (.*);

	boot_rom #(
		.ROM_WORDS(ROM_WORDS)
	) u_rom (
		.cpu_clk,
		.rst_n_i,
		.bus(rom_bus)
	);

	scratch_ram #(
		.RAM_WORDS(RAM_WORDS),
		.RAM_WAIT(RAM_WAIT)
	) u_ram (
		.cpu_clk,
		.rst_n_i,
		.bus(ram_bus)
	);

	prng_unit u_prng (
		.cpu_clk,
		.rst_n_i,
		.bus(prng_bus)
	);

	led_port #(
		.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
	) u_led (
		.cpu_clk,
		.rst_n_i,
		.bus(led_bus),
		.btn_i,
		.led_o
	);

endmodule

// ==== v68k_sys_assert.sv ====
/* Bus handshake checker, bound into the bus decoder.
   Flags overlapping replies, multiple selects and an early dtack release */
`timescale 1ns/1ps

module v68k_sys_assert (
	input logic       cpu_clk,
	input logic       rst_n_i,
	input logic       as_n_i,
	input logic       dtack_n_i,
	input logic       berr_i,
	input logic [3:0] sel_i
);

	// Normal reply and bus error are exclusive
	dtack_berr_excl: assert property (@(posedge cpu_clk) disable iff (!rst_n_i)
		!(!dtack_n_i && berr_i))
		else $error("dtack_n_o low while berr_o high");

	// Address map regions never overlap
	sel_onehot: assert property (@(posedge cpu_clk) disable iff (!rst_n_i)
		$onehot0(sel_i))
		else $error("more than one slave select active");

	// Acknowledge held for as long as the master keeps the strobe
	dtack_held: assert property (@(posedge cpu_clk) disable iff (!rst_n_i)
		(!dtack_n_i && !as_n_i) |=> !dtack_n_i)
		else $error("dtack_n_o released before as_n_i rose");

endmodule

// Selects packed rom, ram, prng, led
bind bus_decoder v68k_sys_assert u_bus_chk (
	.cpu_clk(cpu_clk),
	.rst_n_i(rst_n_i),
	.as_n_i(as_n_i),
	.dtack_n_i(dtack_n_o),
	.berr_i(berr_o),
	.sel_i({cs_rom, cs_ram, cs_prng, cs_led})
);
